// ==== logic/muldiv_pkg.sv ====
// -------------------------------------------------------------------
// muldiv shared definitions
// function codes, widths, counter limits and the result word layout
// -------------------------------------------------------------------

`default_nettype none

package muldiv_pkg;

  // -----------------------------------------------------------------
  // widths
  // -----------------------------------------------------------------

  // operand width
  localparam int unsigned xlen = 32;
  // request tag, lets the receiver match out of order responses
  localparam int unsigned tag_w = 4;
  localparam int unsigned fn_w = 2;
  // iteration counter, wide enough to hold iter_count itself
  localparam int unsigned cnt_w = 6;

  // function codes
  localparam logic [fn_w-1:0] fn_mul  = 2'd0;
  localparam logic [fn_w-1:0] fn_mulu = 2'd1;
  localparam logic [fn_w-1:0] fn_div  = 2'd2;
  localparam logic [fn_w-1:0] fn_divu = 2'd3;

  // one result bit per iteration in both units
  localparam logic [cnt_w-1:0] iter_count = 6'd32;

  // -----------------------------------------------------------------
  // unit control states, shared by multiplier and divider
  // -----------------------------------------------------------------

  localparam int unsigned state_w = 2;
  localparam logic [state_w-1:0] st_idle = 2'd0;
  localparam logic [state_w-1:0] st_calc = 2'd1;
  localparam logic [state_w-1:0] st_done = 2'd2;

  // result word
  // divider fills {rem, quot}, multiplier fills {hi, lo}
  typedef union packed {
    struct packed {
      logic [xlen-1:0] rem;
      logic [xlen-1:0] quot;
    } div;
    struct packed {
      logic [xlen-1:0] hi;
      logic [xlen-1:0] lo;
    } mul;
  } muldiv_result_u;

endpackage

`default_nettype wire

// ==== logic/int_div_iterative.sv ====
// -------------------------------------------------------------------
// iterative restoring divider
// one quotient bit per cycle, signed and unsigned, fixed div by zero
// -------------------------------------------------------------------

`default_nettype none

module int_div_iterative (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              req_val,
  input  wire [muldiv_pkg::fn_w-1:0]       req_fn,
  input  wire [muldiv_pkg::tag_w-1:0]      req_tag,
  input  wire [muldiv_pkg::xlen-1:0]       req_a,
  input  wire [muldiv_pkg::xlen-1:0]       req_b,
  output logic                             req_rdy,
  output logic                             resp_val,
  output logic [muldiv_pkg::tag_w-1:0]     resp_tag,
  output muldiv_pkg::muldiv_result_u       resp_result,
  input  wire                              resp_rdy
);

  // control
  logic [muldiv_pkg::state_w-1:0] state;
  logic [muldiv_pkg::cnt_w-1:0]   count;
  logic                           req_go;
  logic                           resp_go;
  logic                           step;

  // datapath, {guard, remainder, quotient}
  logic [2*muldiv_pkg::xlen:0]    rq_reg;
  logic [muldiv_pkg::xlen-1:0]    dvsr_reg;
  logic                           signed_reg;
  logic                           quot_neg_reg;
  logic                           rem_neg_reg;
  logic                           zero_reg;

  logic                           is_signed;
  logic [muldiv_pkg::xlen-1:0]    a_mag;
  logic [muldiv_pkg::xlen-1:0]    b_mag;
  logic [2*muldiv_pkg::xlen:0]    shift_out;
  logic [2*muldiv_pkg::xlen:0]    sub_out;
  logic [muldiv_pkg::xlen-1:0]    quot_mag;
  logic [muldiv_pkg::xlen-1:0]    rem_mag;

  // -----------------------------------------------------------------
  // control FSM
  // -----------------------------------------------------------------

  assign req_rdy  = (state == muldiv_pkg::st_idle);
  assign resp_val = (state == muldiv_pkg::st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  // last CALC cycle only moves to DONE, no datapath update
  assign step = (state == muldiv_pkg::st_calc) && (count != muldiv_pkg::iter_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_pkg::st_calc;
            count <= '0;
          end
        end
        muldiv_pkg::st_calc: begin
          if (count == muldiv_pkg::iter_count) begin
            state <= muldiv_pkg::st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::st_done: begin
          // hold the result until the arbiter takes it
          if (resp_go) begin
            state <= muldiv_pkg::st_idle;
          end
        end
        default: state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  // -----------------------------------------------------------------
  // datapath
  // -----------------------------------------------------------------

  // operands become magnitudes up front, signs are reapplied at the end
  assign is_signed = (req_fn == muldiv_pkg::fn_div);
  assign a_mag = (is_signed && req_a[muldiv_pkg::xlen-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (is_signed && req_b[muldiv_pkg::xlen-1]) ? (~req_b + 1'b1) : req_b;

  // shift, then trial subtract of the divisor aligned to the remainder half
  assign shift_out = rq_reg << 1;
  assign sub_out = shift_out - {1'b0, dvsr_reg, {muldiv_pkg::xlen{1'b0}}};

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg       <= {{(muldiv_pkg::xlen + 1){1'b0}}, a_mag};
      dvsr_reg     <= b_mag;
      resp_tag     <= req_tag;
      signed_reg   <= is_signed;
      quot_neg_reg <= req_a[muldiv_pkg::xlen-1] ^ req_b[muldiv_pkg::xlen-1];
      // remainder takes the sign of the dividend
      rem_neg_reg  <= req_a[muldiv_pkg::xlen-1];
      zero_reg     <= (req_b == '0);
    end else if (step) begin
      // negative trial means restore and shift in a zero
      rq_reg <= sub_out[2*muldiv_pkg::xlen] ? shift_out :
                {sub_out[2*muldiv_pkg::xlen:1], 1'b1};
    end
  end

  assign quot_mag = rq_reg[muldiv_pkg::xlen-1:0];
  assign rem_mag  = rq_reg[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];

  // divide by zero leaves a in the remainder half on its own,
  // only the quotient needs forcing to all ones
  always_comb begin
    if (zero_reg) begin
      resp_result.div.quot = '1;
    end else if (signed_reg && quot_neg_reg) begin
      resp_result.div.quot = ~quot_mag + 1'b1;
    end else begin
      resp_result.div.quot = quot_mag;
    end
    resp_result.div.rem = (signed_reg && rem_neg_reg) ? (~rem_mag + 1'b1) : rem_mag;
  end

  // held result must not move while it waits for the arbiter
  assert property (@(posedge clk) disable iff (reset)
    (state == muldiv_pkg::st_done) |=> $stable(rq_reg));
  assert property (@(posedge clk) disable iff (reset) count <= muldiv_pkg::iter_count);

endmodule

`default_nettype wire

// ==== logic/int_mul_iterative.sv ====
// -------------------------------------------------------------------
// iterative shift-and-add multiplier, full 64-bit product
// -------------------------------------------------------------------

`default_nettype none

module int_mul_iterative (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              req_val,
  input  wire [muldiv_pkg::fn_w-1:0]       req_fn,
  input  wire [muldiv_pkg::tag_w-1:0]      req_tag,
  input  wire [muldiv_pkg::xlen-1:0]       req_a,
  input  wire [muldiv_pkg::xlen-1:0]       req_b,
  output logic                             req_rdy,
  output logic                             resp_val,
  output logic [muldiv_pkg::tag_w-1:0]     resp_tag,
  output muldiv_pkg::muldiv_result_u       resp_result,
  input  wire                              resp_rdy
);

  logic [muldiv_pkg::state_w-1:0] state;
  logic [muldiv_pkg::cnt_w-1:0]   count;
  logic                           req_go;
  logic                           resp_go;
  logic                           step;

  logic [2*muldiv_pkg::xlen-1:0]  acc;
  logic [2*muldiv_pkg::xlen-1:0]  mcand;
  logic [muldiv_pkg::xlen-1:0]    mplier;
  logic                           neg_reg;
  logic                           is_signed;
  logic [muldiv_pkg::xlen-1:0]    a_mag;
  logic [muldiv_pkg::xlen-1:0]    b_mag;
  logic [2*muldiv_pkg::xlen-1:0]  prod;

  // -----------------------------------------------------------------
  // control, same IDLE/CALC/DONE timing as the divider
  // -----------------------------------------------------------------

  assign req_rdy  = (state == muldiv_pkg::st_idle);
  assign resp_val = (state == muldiv_pkg::st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  assign step = (state == muldiv_pkg::st_calc) && (count != muldiv_pkg::iter_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::st_idle: begin
          if (req_go) begin
            state <= muldiv_pkg::st_calc;
            count <= '0;
          end
        end
        muldiv_pkg::st_calc: begin
          if (count == muldiv_pkg::iter_count) begin
            state <= muldiv_pkg::st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        muldiv_pkg::st_done: begin
          if (resp_go) begin
            state <= muldiv_pkg::st_idle;
          end
        end
        default: state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  // -----------------------------------------------------------------
  // datapath
  // -----------------------------------------------------------------

  // fn_mulu takes both operands as they are
  assign is_signed = (req_fn == muldiv_pkg::fn_mul);
  assign a_mag = (is_signed && req_a[muldiv_pkg::xlen-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (is_signed && req_b[muldiv_pkg::xlen-1]) ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      acc      <= '0;
      mcand    <= {{muldiv_pkg::xlen{1'b0}}, a_mag};
      mplier   <= b_mag;
      neg_reg  <= is_signed && (req_a[muldiv_pkg::xlen-1] ^ req_b[muldiv_pkg::xlen-1]);
      resp_tag <= req_tag;
    end else if (step) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // magnitude product is at most 2^62, so negation stays in range
  assign prod = neg_reg ? (~acc + 1'b1) : acc;

  always_comb begin
    resp_result.mul.hi = prod[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
    resp_result.mul.lo = prod[muldiv_pkg::xlen-1:0];
  end

  // result must not move while it waits for the arbiter
  assert property (@(posedge clk) disable iff (reset)
    (state == muldiv_pkg::st_done) |=> $stable(acc));

endmodule

`default_nettype wire

// ==== logic/muldiv_resp_arbiter.sv ====
// -------------------------------------------------------------------
// round-robin arbiter, merges the two unit responses onto one port
// -------------------------------------------------------------------

`default_nettype none

module muldiv_resp_arbiter (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              mul_val,
  input  wire [muldiv_pkg::tag_w-1:0]      mul_tag,
  input  wire muldiv_pkg::muldiv_result_u  mul_result,
  output logic                             mul_rdy,
  input  wire                              div_val,
  input  wire [muldiv_pkg::tag_w-1:0]      div_tag,
  input  wire muldiv_pkg::muldiv_result_u  div_result,
  output logic                             div_rdy,
  output logic                             resp_val,
  output logic [muldiv_pkg::tag_w-1:0]     resp_tag,
  output muldiv_pkg::muldiv_result_u       resp_result,
  input  wire                              resp_rdy
);

  // high when the multiplier won last, so it loses the next tie
  logic last_mul;
  logic grant_mul;

  assign grant_mul = mul_val && !(div_val && last_mul);

  assign resp_val    = mul_val || div_val;
  assign resp_tag    = grant_mul ? mul_tag : div_tag;
  assign resp_result = grant_mul ? mul_result : div_result;

  // back-pressure reaches only the granted unit
  assign mul_rdy = resp_rdy && grant_mul;
  assign div_rdy = resp_rdy && div_val && !grant_mul;

  // on a transfer record the winner; on a stall point the register at
  // the other unit so a late arrival cannot steal the held grant
  always_ff @(posedge clk) begin
    if (reset) begin
      last_mul <= 1'b1;
    end else if (resp_val) begin
      last_mul <= resp_rdy ? grant_mul : !grant_mul;
    end
  end

  // a stalled response keeps its grant until it is taken
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (grant_mul == $past(grant_mul)));

endmodule

`default_nettype wire

// ==== logic/muldiv_unit.sv ====
// -------------------------------------------------------------------
// muldiv top level
// steers requests by function code, merges responses through the arbiter
// -------------------------------------------------------------------

`default_nettype none

module muldiv_unit (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              req_val,
  input  wire [muldiv_pkg::fn_w-1:0]       req_fn,
  input  wire [muldiv_pkg::tag_w-1:0]      req_tag,
  input  wire [muldiv_pkg::xlen-1:0]       req_a,
  input  wire [muldiv_pkg::xlen-1:0]       req_b,
  output logic                             req_rdy,
  output logic                             resp_val,
  output logic [muldiv_pkg::tag_w-1:0]     resp_tag,
  output muldiv_pkg::muldiv_result_u       resp_result,
  input  wire                              resp_rdy
);

  logic                           is_mul;
  logic                           mul_req_rdy;
  logic                           div_req_rdy;
  logic                           mul_val;
  logic                           div_val;
  logic                           mul_rdy;
  logic                           div_rdy;
  logic [muldiv_pkg::tag_w-1:0]   mul_tag;
  logic [muldiv_pkg::tag_w-1:0]   div_tag;
  muldiv_pkg::muldiv_result_u     mul_result;
  muldiv_pkg::muldiv_result_u     div_result;

  // both multiply codes go to the multiplier, the rest to the divider
  assign is_mul  = (req_fn == muldiv_pkg::fn_mul) || (req_fn == muldiv_pkg::fn_mulu);
  assign req_rdy = is_mul ? mul_req_rdy : div_req_rdy;

  int_mul_iterative mul_inst (
    .clk(clk), .reset(reset),
    .req_val(req_val && is_mul), .req_fn(req_fn), .req_tag(req_tag),
    .req_a(req_a), .req_b(req_b), .req_rdy(mul_req_rdy),
    .resp_val(mul_val), .resp_tag(mul_tag), .resp_result(mul_result),
    .resp_rdy(mul_rdy)
  );

  int_div_iterative div_inst (
    .clk(clk), .reset(reset),
    .req_val(req_val && !is_mul), .req_fn(req_fn), .req_tag(req_tag),
    .req_a(req_a), .req_b(req_b), .req_rdy(div_req_rdy),
    .resp_val(div_val), .resp_tag(div_tag), .resp_result(div_result),
    .resp_rdy(div_rdy)
  );

  muldiv_resp_arbiter arb_inst (
    .clk(clk), .reset(reset),
    .mul_val(mul_val), .mul_tag(mul_tag), .mul_result(mul_result), .mul_rdy(mul_rdy),
    .div_val(div_val), .div_tag(div_tag), .div_result(div_result), .div_rdy(div_rdy),
    .resp_val(resp_val), .resp_tag(resp_tag), .resp_result(resp_result),
    .resp_rdy(resp_rdy)
  );

endmodule

`default_nettype wire

// ==== dv/muldiv_unit_tb.sv ====
// ----------------------------------------------------------------------
// muldiv unit testbench
// directed tests, tag scoreboard and a reference model
// ----------------------------------------------------------------------

`default_nettype none

module muldiv_unit_tb;

  localparam int clk_period = 4;
  // reset check, divides, multiplies, stall pair and the random run
  localparam int num_reqs = 61;
  localparam int watchdog_cycles = num_reqs * 40 + 300;
  localparam int tags = 1 << muldiv_pkg::tag_w;

  logic                         clk;
  logic                         reset;
  logic                         req_val;
  logic [muldiv_pkg::fn_w-1:0]  req_fn;
  logic [muldiv_pkg::tag_w-1:0] req_tag;
  logic [31:0]                  req_a;
  logic [31:0]                  req_b;
  logic                         req_rdy;
  logic                         resp_val;
  logic [muldiv_pkg::tag_w-1:0] resp_tag;
  muldiv_pkg::muldiv_result_u   resp_result;
  logic                         resp_rdy;

  // scoreboard, one slot per tag
  muldiv_pkg::muldiv_result_u   exp_result [tags];
  logic [muldiv_pkg::fn_w-1:0]  exp_fn [tags];
  logic [tags-1:0]              pending;
  logic [muldiv_pkg::tag_w-1:0] mon_tag;
  logic [31:0]                  rdy_rnd;
  int                           outstanding;
  int                           errors;
  int                           checks;
  // 0 always ready, 1 held low, 2 random
  int                           rdy_mode;
  int                           rdy_mode_q;
  integer                       op_seed;
  integer                       rdy_seed;
  string                        cur_test;

  muldiv_unit muldiv_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // expected result straight from the arithmetic rules
  function automatic logic [63:0] model_result(input logic [1:0] fn, input logic [31:0] a,
                                               input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        q;
    logic [63:0]        r;
    logic [63:0]        res;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};
    ub = {32'd0, b};
    if (fn == muldiv_pkg::fn_mul) begin
      res = sa * sb;
    end else if (fn == muldiv_pkg::fn_mulu) begin
      res = ua * ub;
    end else if (b == 32'd0) begin
      // divide by zero, quotient all ones and remainder a
      res = {a, 32'hffff_ffff};
    end else begin
      if (fn == muldiv_pkg::fn_div) begin
        q = sa / sb;
        r = sa % sb;
      end else begin
        q = ua / ub;
        r = ua % ub;
      end
      res = {r[31:0], q[31:0]};
    end
    return res;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_req(input logic [1:0] fn, input logic [3:0] tag, input logic [31:0] a,
                          input logic [31:0] b);
    // a tag can only be reused once its response is back
    while (pending[tag]) step_cycle();
    step_cycle();
    req_val = 1'b1;
    req_fn = fn;
    req_tag = tag;
    req_a = a;
    req_b = b;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    step_cycle();
    req_val = 1'b0;
    exp_result[tag] = model_result(fn, a, b);
    exp_fn[tag] = fn;
    pending[tag] = 1'b1;
    outstanding++;
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    int t;
    cycles = 0;
    while (outstanding != 0 && cycles < limit) begin
      step_cycle();
      cycles++;
    end
    for (t = 0; t < tags; t++) begin
      if (pending[t]) begin
        errors++;
        $display("%s: response for tag %0d never arrived", cur_test, t);
        pending[t] = 1'b0;
      end
    end
    outstanding = 0;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic reset_state_test();
    cur_test = "reset_state";
    req_fn = muldiv_pkg::fn_mul;
    @(negedge clk);
    checks += 3;
    if (resp_val !== 1'b0) begin
      errors++;
      $display("FAILED %s: expected resp_val 0 actual %b", cur_test, resp_val);
    end
    if (req_rdy !== 1'b1) begin
      errors++;
      $display("FAILED %s: expected multiply req_rdy 1 actual %b", cur_test, req_rdy);
    end
    step_cycle();
    req_fn = muldiv_pkg::fn_divu;
    @(negedge clk);
    if (req_rdy !== 1'b1) begin
      errors++;
      $display("FAILED %s: expected divide req_rdy 1 actual %b", cur_test, req_rdy);
    end
    step_cycle();
  endtask

  task automatic divu_test();
    cur_test = "divu";
    send_req(muldiv_pkg::fn_divu, 4'd0, 32'hffff_fff0, 32'd7);
    send_req(muldiv_pkg::fn_divu, 4'd1, 32'd5, 32'd1000);
    send_req(muldiv_pkg::fn_divu, 4'd2, 32'h1234_5678, 32'h1234_5678);
    send_req(muldiv_pkg::fn_divu, 4'd3, 32'hdead_beef, 32'd0);
    send_req(muldiv_pkg::fn_divu, 4'd4, 32'h8000_0000, 32'd3);
    wait_drain(200);
  endtask

  task automatic div_test();
    cur_test = "div";
    send_req(muldiv_pkg::fn_div, 4'd5, 32'd100, 32'd7);
    send_req(muldiv_pkg::fn_div, 4'd6, 32'hffff_ff9c, 32'd7);
    send_req(muldiv_pkg::fn_div, 4'd7, 32'd100, 32'hffff_fff9);
    send_req(muldiv_pkg::fn_div, 4'd8, 32'hffff_ff9c, 32'hffff_fff9);
    // most negative over minus one
    send_req(muldiv_pkg::fn_div, 4'd9, 32'h8000_0000, 32'hffff_ffff);
    send_req(muldiv_pkg::fn_div, 4'd10, 32'hffff_fff7, 32'd0);
    wait_drain(200);
  endtask

  task automatic mul_test();
    cur_test = "mul";
    send_req(muldiv_pkg::fn_mul, 4'd11, 32'd0, 32'h1234_5678);
    send_req(muldiv_pkg::fn_mul, 4'd12, 32'd1, 32'hffff_fffb);
    send_req(muldiv_pkg::fn_mul, 4'd13, 32'hffff_ffff, 32'hffff_ffff);
    send_req(muldiv_pkg::fn_mul, 4'd14, 32'hffff_fffa, 32'd7);
    send_req(muldiv_pkg::fn_mul, 4'd15, 32'h8000_0000, 32'h8000_0000);
    send_req(muldiv_pkg::fn_mulu, 4'd0, 32'hffff_ffff, 32'hffff_ffff);
    send_req(muldiv_pkg::fn_mulu, 4'd1, 32'd1, 32'hffff_ffff);
    send_req(muldiv_pkg::fn_mulu, 4'd2, 32'd0, 32'hffff_ffff);
    wait_drain(200);
  endtask

  task automatic stall_test();
    cur_test = "stall";
    rdy_mode = 1;
    send_req(muldiv_pkg::fn_mulu, 4'd3, 32'h0001_0003, 32'h0002_0005);
    send_req(muldiv_pkg::fn_div, 4'd4, 32'hffff_8000, 32'd12);
    repeat (50) step_cycle();
    checks += 3;
    if (resp_val !== 1'b1) begin
      errors++;
      $display("FAILED %s: expected resp_val 1 actual %b", cur_test, resp_val);
    end
    // both units still hold a result, so neither takes a new request
    req_fn = muldiv_pkg::fn_mulu;
    @(negedge clk);
    if (req_rdy !== 1'b0) begin
      errors++;
      $display("FAILED %s: expected multiply req_rdy 0 actual %b", cur_test, req_rdy);
    end
    step_cycle();
    req_fn = muldiv_pkg::fn_div;
    @(negedge clk);
    if (req_rdy !== 1'b0) begin
      errors++;
      $display("FAILED %s: expected divide req_rdy 0 actual %b", cur_test, req_rdy);
    end
    rdy_mode = 0;
    wait_drain(100);
  endtask

  task automatic random_test();
    int          i;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    cur_test = "random";
    rdy_mode = 2;
    for (i = 0; i < 40; i++) begin
      r = $random(op_seed);
      a = $random(op_seed);
      b = $random(op_seed);
      // shrink the divisor now and then for larger quotients
      send_req(r[1:0], i[3:0], a, b >> r[6:2]);
    end
    rdy_mode = 0;
    wait_drain(200);
  endtask

  // resp_rdy follows the mode sampled at the edge
  initial begin
    forever begin
      @(posedge clk);
      rdy_mode_q = rdy_mode;
      #1;
      rdy_rnd = $random(rdy_seed);
      resp_rdy = (rdy_mode_q == 0) || (rdy_mode_q == 2 && rdy_rnd[0]);
    end
  end

  // response monitor, a transfer completes on the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      if (!reset && resp_val && resp_rdy) begin
        mon_tag = resp_tag;
        if (!pending[mon_tag]) begin
          errors++;
          $display("%s: response with tag %0d was not outstanding", cur_test, mon_tag);
        end else begin
          checks++;
          if (exp_fn[mon_tag] inside {muldiv_pkg::fn_mul, muldiv_pkg::fn_mulu}) begin
            if ({resp_result.mul.hi, resp_result.mul.lo} !==
                {exp_result[mon_tag].mul.hi, exp_result[mon_tag].mul.lo}) begin
              errors++;
              $display("FAILED %s: tag %0d expected hi %h lo %h actual hi %h lo %h",
                       cur_test, mon_tag,
                       exp_result[mon_tag].mul.hi, exp_result[mon_tag].mul.lo,
                       resp_result.mul.hi, resp_result.mul.lo);
            end
          end else if ({resp_result.div.rem, resp_result.div.quot} !==
                       {exp_result[mon_tag].div.rem, exp_result[mon_tag].div.quot}) begin
            errors++;
            $display("FAILED %s: tag %0d expected rem %h quot %h actual rem %h quot %h",
                     cur_test, mon_tag,
                     exp_result[mon_tag].div.rem, exp_result[mon_tag].div.quot,
                     resp_result.div.rem, resp_result.div.quot);
          end
          pending[mon_tag] = 1'b0;
          outstanding--;
        end
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = '0;
    req_tag = '0;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b1;
    pending = '0;
    outstanding = 0;
    errors = 0;
    checks = 0;
    rdy_mode = 0;
    op_seed = 32'h7d38348c;
    rdy_seed = ~32'h7d38348c;
    cur_test = "reset";
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state_test();
    divu_test();
    div_test();
    mul_test();
    stall_test();
    random_test();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/muldiv_pkg.sv
logic/int_div_iterative.sv
logic/int_mul_iterative.sv
logic/muldiv_resp_arbiter.sv
logic/muldiv_unit.sv
dv/muldiv_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the muldiv unit

VERILATOR ?= verilator
TOP       ?= muldiv_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
